// ==== build.f ====
logic/core_pkg.sv
logic/lsu_pkg.sv
logic/iq_write_if.sv
logic/lsu_req_if.sv
logic/lsu_iq_ctrl.sv
logic/lsu_iq_store.sv
logic/lsu_req_gen.sv
logic/lsu_resp_fifo.sv
logic/lsu_issue_top.sv
sim/tb_lsu_issue.sv

// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // reorder-buffer tag, 32 entries
    typedef logic [4:0] rob_id_t;

    typedef logic [31:0] word_t;

    // one result-bus broadcast
    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

endpackage

`default_nettype wire

// ==== logic/iq_write_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface iq_write_if;

    import lsu_pkg::*;

    logic [LSU_IQ_DEPTH-1:0] wr_sel0;    // one-hot target of dispatch slot 0
    logic [LSU_IQ_DEPTH-1:0] wr_sel1;    // one-hot target of dispatch slot 1
    logic [LSU_IQ_PTR_W-1:0] issue_sel;  // head index
    logic                    issue_fire;
    logic                    head_ready; // head valid with operands in

    modport ctrl (output wr_sel0, wr_sel1, issue_sel, issue_fire, input head_ready);
    modport store (input wr_sel0, wr_sel1, issue_sel, issue_fire, output head_ready);

endinterface

`default_nettype wire

// ==== logic/lsu_iq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_iq_ctrl (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       flush_i,
    input  logic [1:0] disp_valid_i,
    output logic       disp_ready_o,
    iq_write_if.ctrl   wr,
    input  logic       take_i
);

    import lsu_pkg::*;

    logic [LSU_IQ_PTR_W-1:0] head_q;    // oldest entry
    logic [LSU_IQ_PTR_W-1:0] tail_q;    // next free entry
    logic [LSU_IQ_PTR_W-1:0] tail_p1_q; // the one after it
    logic [LSU_IQ_PTR_W:0]   cnt_q;
    logic [LSU_IQ_PTR_W:0]   cnt_nxt;
    logic [1:0]              acc;
    logic [1:0]              n_acc;
    logic                    fire;

    assign acc   = disp_valid_i & {2{disp_ready_o}};
    assign n_acc = {1'b0, acc[0]} + {1'b0, acc[1]};
    assign fire  = wr.head_ready & take_i;

    assign wr.issue_fire = fire;
    assign wr.issue_sel  = head_q;

    // slot 1 lands right behind slot 0, or at the tail when it comes alone
    always_comb begin
        for (int i = 0; i < LSU_IQ_DEPTH; i++) begin
            wr.wr_sel0[i] = acc[0] && (tail_q == LSU_IQ_PTR_W'(i));
            if (acc[0]) begin
                wr.wr_sel1[i] = acc[1] && (tail_p1_q == LSU_IQ_PTR_W'(i));
            end else begin
                wr.wr_sel1[i] = acc[1] && (tail_q == LSU_IQ_PTR_W'(i));
            end
        end
    end

    assign cnt_nxt = cnt_q + (LSU_IQ_PTR_W+1)'(n_acc) - (LSU_IQ_PTR_W+1)'(fire);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q       <= '0;
            tail_q       <= '0;
            tail_p1_q    <= LSU_IQ_PTR_W'(1);
            cnt_q        <= '0;
            disp_ready_o <= 1'b1;
        end else if (flush_i) begin
            head_q       <= '0;
            tail_q       <= '0;
            tail_p1_q    <= LSU_IQ_PTR_W'(1);
            cnt_q        <= '0;
            disp_ready_o <= 1'b1;
        end else begin
            head_q       <= head_q + LSU_IQ_PTR_W'(fire);
            tail_q       <= tail_q + LSU_IQ_PTR_W'(n_acc);
            tail_p1_q    <= tail_p1_q + LSU_IQ_PTR_W'(n_acc);
            cnt_q        <= cnt_nxt;
            // room for a full pair next cycle
            disp_ready_o <= cnt_nxt <= (LSU_IQ_PTR_W+1)'(LSU_IQ_DEPTH - 2);
        end
    end

    cnt_bound_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        cnt_q <= (LSU_IQ_PTR_W+1)'(LSU_IQ_DEPTH));

endmodule

`default_nettype wire

// ==== logic/lsu_iq_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_iq_store (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    flush_i,
    input  lsu_pkg::lsu_uop_t [1:0] disp_uop_i,
    input  core_pkg::cdb_t          cdb_snoop_i,
    iq_write_if.store               wr,
    lsu_req_if.store                rq
);

    import core_pkg::*;
    import lsu_pkg::*;

    lsu_uop_t                ent_q [LSU_IQ_DEPTH];
    logic [LSU_IQ_DEPTH-1:0] vld_q;
    lsu_uop_t [1:0]          in_uop; // dispatch payload after snoop
    lsu_uop_t                head;
    logic                    head_ok;

    // capture broadcast data for a pending operand with a matching tag
    function automatic lsu_opnd_t snoop(input lsu_opnd_t opnd, input cdb_t cdb);
        lsu_opnd_t res;
        res = opnd;
        if (!opnd.rdy && cdb.valid && (cdb.tag == opnd.tag)) begin
            res.rdy  = 1'b1;
            res.data = cdb.data;
        end
        return res;
    endfunction

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            in_uop[s]       = disp_uop_i[s];
            in_uop[s].base  = snoop(disp_uop_i[s].base, cdb_snoop_i);
            in_uop[s].sdata = snoop(disp_uop_i[s].sdata, cdb_snoop_i);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LSU_IQ_DEPTH; i++) begin
            if (wr.wr_sel0[i]) begin
                ent_q[i] <= in_uop[0];
            end else if (wr.wr_sel1[i]) begin
                ent_q[i] <= in_uop[1];
            end else begin
                // wakeup, ready operands pass through unchanged
                ent_q[i].base  <= snoop(ent_q[i].base, cdb_snoop_i);
                ent_q[i].sdata <= snoop(ent_q[i].sdata, cdb_snoop_i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else if (flush_i) begin
            vld_q <= '0;
        end else begin
            for (int i = 0; i < LSU_IQ_DEPTH; i++) begin
                if (wr.wr_sel0[i] || wr.wr_sel1[i]) begin
                    vld_q[i] <= 1'b1;
                end else if (wr.issue_fire && (wr.issue_sel == LSU_IQ_PTR_W'(i))) begin
                    vld_q[i] <= 1'b0;
                end
            end
        end
    end

    assign head = ent_q[wr.issue_sel];

    // loads never wait on store data
    assign head_ok = vld_q[wr.issue_sel] && head.base.rdy &&
                     ((head.op == MEM_LOAD) || head.sdata.rdy);

    assign wr.head_ready = head_ok;
    assign rq.head_valid = head_ok;
    assign rq.head_uop   = head;

endmodule

`default_nettype wire

// ==== logic/lsu_issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_top (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    flush_i,
    input  logic [1:0]              disp_valid_i,
    input  lsu_pkg::lsu_uop_t [1:0] disp_uop_i,
    output logic                    disp_ready_o,
    input  core_pkg::cdb_t          cdb_snoop_i,
    output logic                    mem_req_valid_o,
    input  logic                    mem_req_ready_i,
    output lsu_pkg::lsu_req_t       mem_req_o,
    input  logic                    mem_resp_valid_i,
    output logic                    mem_resp_ready_o,
    input  lsu_pkg::lsu_resp_t      mem_resp_i,
    output core_pkg::cdb_t          cdb_o,
    input  logic                    cdb_ready_i
);

    iq_write_if wr_bus ();
    lsu_req_if  rq_bus ();

    lsu_iq_ctrl u_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .disp_ready_o (disp_ready_o),
        .wr           (wr_bus.ctrl),
        .take_i       (rq_bus.take)
    );

    lsu_iq_store u_store (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .disp_uop_i  (disp_uop_i),
        .cdb_snoop_i (cdb_snoop_i),
        .wr          (wr_bus.store),
        .rq          (rq_bus.store)
    );

    lsu_req_gen u_req_gen (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .flush_i         (flush_i),
        .rq              (rq_bus.gen),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_o       (mem_req_o)
    );

    lsu_resp_fifo u_resp_fifo (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .resp_valid_i (mem_resp_valid_i),
        .resp_ready_o (mem_resp_ready_o),
        .resp_i       (mem_resp_i),
        .cdb_o        (cdb_o),
        .cdb_ready_i  (cdb_ready_i)
    );

endmodule

`default_nettype wire

// ==== logic/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    import core_pkg::*;

    localparam int LSU_IQ_DEPTH   = 8;
    localparam int LSU_RESP_DEPTH = 4;
    localparam int LSU_IQ_PTR_W   = $clog2(LSU_IQ_DEPTH);
    localparam int LSU_RESP_PTR_W = $clog2(LSU_RESP_DEPTH);

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    // source operand, data valid once rdy is set
    typedef struct packed {
        rob_id_t tag;
        logic    rdy;
        word_t   data;
    } lsu_opnd_t;

    typedef struct packed {
        mem_op_e    op;
        mem_size_e  size;
        logic       sign;
        logic [11:0] imm;
        rob_id_t    dst;
        lsu_opnd_t  base;  // address base
        lsu_opnd_t  sdata; // store data, unused by loads
    } lsu_uop_t;

    typedef struct packed {
        rob_id_t    tag;
        mem_op_e    op;
        mem_size_e  size;
        logic       sign;
        logic [31:0] vaddr;
        logic [3:0] strb;
        word_t      wdata;
    } lsu_req_t;

    typedef struct packed {
        rob_id_t tag;
        word_t   rdata;
    } lsu_resp_t;

endpackage

`default_nettype wire

// ==== logic/lsu_req_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_req_gen (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              flush_i,
    lsu_req_if.gen            rq,
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    output lsu_pkg::lsu_req_t mem_req_o
);

    import lsu_pkg::*;

    logic     iss_vld_q;
    lsu_uop_t iss_q;     // issued micro-op
    logic     take;
    lsu_req_t req;

    assign take    = !iss_vld_q || mem_req_ready_i;
    assign rq.take = take;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            iss_vld_q <= 1'b0;
        end else if (flush_i) begin
            iss_vld_q <= 1'b0;
        end else if (take) begin
            iss_vld_q <= rq.head_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take && rq.head_valid) begin
            iss_q <= rq.head_uop;
        end
    end

    always_comb begin
        req       = '0;
        req.tag   = iss_q.dst;
        req.op    = iss_q.op;
        req.size  = iss_q.size;
        req.sign  = iss_q.sign;
        req.vaddr = iss_q.base.data + {{20{iss_q.imm[11]}}, iss_q.imm};
        if (iss_q.op == MEM_STORE) begin
            case (iss_q.size)
                MEM_WORD: begin
                    req.strb  = 4'b1111;
                    req.wdata = iss_q.sdata.data;
                end
                MEM_HALF: begin
                    req.strb  = 4'b0011 << {req.vaddr[1], 1'b0};
                    req.wdata = iss_q.sdata.data << {req.vaddr[1], 4'd0}; // upper or lower half
                end
                default: begin
                    req.strb  = 4'b0001 << req.vaddr[1:0];
                    req.wdata = iss_q.sdata.data << {req.vaddr[1:0], 3'd0};
                end
            endcase
        end
    end

    assign mem_req_valid_o = iss_vld_q;
    assign mem_req_o       = req;

    req_stable_a: assert property (@(posedge clk) disable iff (!arst_n_i || flush_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

`default_nettype wire

// ==== logic/lsu_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lsu_req_if;

    import lsu_pkg::*;

    lsu_uop_t head_uop;   // oldest entry, captured operands included
    logic     head_valid; // head can issue
    logic     take;       // issue register free or draining this cycle

    modport store (output head_uop, head_valid);
    modport gen (input head_uop, head_valid, output take);

endinterface

`default_nettype wire

// ==== logic/lsu_resp_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_resp_fifo (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               flush_i,
    input  logic               resp_valid_i,
    output logic               resp_ready_o,
    input  lsu_pkg::lsu_resp_t resp_i,
    output core_pkg::cdb_t     cdb_o,
    input  logic               cdb_ready_i
);

    import lsu_pkg::*;

    lsu_resp_t                 mem_q [LSU_RESP_DEPTH];
    logic [LSU_RESP_PTR_W-1:0] wptr_q;
    logic [LSU_RESP_PTR_W-1:0] rptr_q;
    logic [LSU_RESP_PTR_W:0]   cnt_q;
    logic                      full;
    logic                      push;
    logic                      pop;

    assign full = cnt_q == (LSU_RESP_PTR_W+1)'(LSU_RESP_DEPTH);
    assign push = resp_valid_i && !full;
    assign pop  = cdb_o.valid && cdb_ready_i;

    assign resp_ready_o = !full;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wptr_q] <= resp_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wptr_q <= '0;
            rptr_q <= '0;
            cnt_q  <= '0;
        end else if (flush_i) begin
            wptr_q <= '0;
            rptr_q <= '0;
            cnt_q  <= '0;
        end else begin
            wptr_q <= wptr_q + LSU_RESP_PTR_W'(push);
            rptr_q <= rptr_q + LSU_RESP_PTR_W'(pop);
            cnt_q  <= cnt_q + (LSU_RESP_PTR_W+1)'(push) - (LSU_RESP_PTR_W+1)'(pop);
        end
    end

    assign cdb_o.valid = cnt_q != '0;
    assign cdb_o.tag   = mem_q[rptr_q].tag;
    assign cdb_o.data  = mem_q[rptr_q].rdata;

    // a write never lands on an unread entry
    no_wr_full_a: assert property (@(posedge clk) disable iff (!arst_n_i || flush_i)
        push |-> (cnt_q == '0) || (wptr_q != rptr_q));

endmodule

`default_nettype wire

// ==== sim/tb_lsu_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_issue;

    import core_pkg::*;
    import lsu_pkg::*;

    localparam int MAX_OPS     = 85; // upper bound over all tests
    localparam int CYCLE_LIMIT = 40 * MAX_OPS + 200;

    logic           clk;
    logic           arst_n_i;
    logic           flush_i;
    logic [1:0]     disp_valid_i;
    lsu_uop_t [1:0] disp_uop_i;
    logic           disp_ready_o;
    cdb_t           cdb_snoop_i;
    logic           mem_req_valid_o;
    logic           mem_req_ready_i;
    lsu_req_t       mem_req_o;
    logic           mem_resp_valid_i;
    logic           mem_resp_ready_o;
    lsu_resp_t      mem_resp_i;
    cdb_t           cdb_o;
    logic           cdb_ready_i;

    integer    seed;
    int        err_cnt = 0;
    int        fail_cnt = 0;
    int        cycles = 0;
    logic      hold_req = 1'b0;  // memory refuses requests
    logic      cdb_hold = 1'b0;  // commit bus refuses broadcasts
    logic      prev_stall = 1'b0;
    lsu_req_t  prev_req;
    lsu_req_t  disp_exp [2];     // expected request per dispatch slot
    lsu_req_t  exp_req [$];
    lsu_resp_t pend_resp [$];    // memory model answers not yet accepted
    lsu_resp_t exp_cdb [$];

    lsu_issue_top UUT (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .flush_i          (flush_i),
        .disp_valid_i     (disp_valid_i),
        .disp_uop_i       (disp_uop_i),
        .disp_ready_o     (disp_ready_o),
        .cdb_snoop_i      (cdb_snoop_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .mem_resp_i       (mem_resp_i),
        .cdb_o            (cdb_o),
        .cdb_ready_i      (cdb_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t addr_hash(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'hc3a5_0f1e;
    endfunction

    // expected request from a micro-op and its resolved operands
    function automatic lsu_req_t ref_req(input lsu_uop_t u, input word_t base, input word_t sd);
        lsu_req_t r;
        r       = '0;
        r.tag   = u.dst;
        r.op    = u.op;
        r.size  = u.size;
        r.sign  = u.sign;
        r.vaddr = base + {{20{u.imm[11]}}, u.imm};
        if (u.op == MEM_STORE) begin
            if (u.size == MEM_WORD) begin
                r.strb  = 4'b1111;
                r.wdata = sd;
            end else if (u.size == MEM_HALF) begin
                r.strb  = r.vaddr[1] ? 4'b1100 : 4'b0011;
                r.wdata = r.vaddr[1] ? {sd[15:0], 16'h0} : sd;
            end else begin
                case (r.vaddr[1:0])
                    2'd0: r.wdata = sd;
                    2'd1: r.wdata = {sd[23:0], 8'h0};
                    2'd2: r.wdata = {sd[15:0], 16'h0};
                    default: r.wdata = {sd[7:0], 24'h0};
                endcase
                r.strb = 4'b0001 << r.vaddr[1:0];
            end
        end
        return r;
    endfunction

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t %s: got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // random micro-op with both operands ready
    task automatic rand_op(output lsu_uop_t u, output lsu_req_t e);
        logic [31:0] r;
        r             = $random(seed);
        u             = '0;
        u.op          = r[0] ? MEM_STORE : MEM_LOAD;
        u.size        = (r[3:2] == 2'd0) ? MEM_BYTE : (r[3:2] == 2'd1) ? MEM_HALF : MEM_WORD;
        u.sign        = r[4];
        u.imm         = r[16:5];
        u.dst         = r[21:17];
        u.base.tag    = r[26:22];
        u.base.rdy    = 1'b1;
        u.base.data   = $random(seed);
        u.sdata.rdy   = 1'b1;
        u.sdata.data  = $random(seed);
        e = ref_req(u, u.base.data, u.sdata.data);
    endtask

    // entered 1 ns after an edge and left 1 ns after the accepting edge
    task automatic dispatch(input logic [1:0] v, input lsu_uop_t u0, input lsu_uop_t u1,
                            input lsu_req_t e0, input lsu_req_t e1, input cdb_t snp);
        while (!disp_ready_o) begin
            @(posedge clk);
            #1;
        end
        disp_valid_i  = v;
        disp_uop_i[0] = u0;
        disp_uop_i[1] = u1;
        disp_exp[0]   = e0;
        disp_exp[1]   = e1;
        cdb_snoop_i   = snp;
        @(posedge clk);
        #1;
        disp_valid_i = 2'b00;
        cdb_snoop_i  = '0;
    endtask

    task automatic snoop_bus(input rob_id_t tag, input word_t data);
        cdb_snoop_i = {1'b1, tag, data};
        @(posedge clk);
        #1;
        cdb_snoop_i = '0;
    endtask

    // change back-pressure away from the memory model's drive point
    task automatic set_holds(input logic req, input logic cdb);
        @(negedge clk);
        hold_req = req;
        cdb_hold = cdb;
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        while (exp_req.size() != 0 || pend_resp.size() != 0 || exp_cdb.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // memory model with handshake bookkeeping and compare
    always @(posedge clk) begin
        logic [31:0] r;
        lsu_resp_t   rsp;
        if (arst_n_i && !flush_i) begin
            for (int s = 0; s < 2; s++) begin
                if (disp_ready_o && disp_valid_i[s]) begin
                    exp_req.push_back(disp_exp[s]);
                end
            end
            if (prev_stall) begin
                check("request valid under stall", mem_req_valid_o, 1'b1);
                check("request stable under stall", mem_req_o, prev_req);
            end
            prev_stall = mem_req_valid_o && !mem_req_ready_i;
            prev_req   = mem_req_o;
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (exp_req.size() == 0) begin
                    fail_cnt++;
                    $display("memory request at %0t with no op expected", $time);
                end else begin
                    check("memory request", mem_req_o, exp_req.pop_front());
                end
                rsp.tag   = mem_req_o.tag;
                rsp.rdata = addr_hash(mem_req_o.vaddr);
                pend_resp.push_back(rsp);
            end
            if (mem_resp_valid_i && mem_resp_ready_o) begin
                exp_cdb.push_back(mem_resp_i);
                void'(pend_resp.pop_front());
            end
            if (cdb_o.valid && cdb_ready_i) begin
                if (exp_cdb.size() == 0) begin
                    fail_cnt++;
                    $display("broadcast at %0t with no response expected", $time);
                end else begin
                    rsp = exp_cdb.pop_front();
                    check("broadcast", {cdb_o.tag, cdb_o.data}, {rsp.tag, rsp.rdata});
                end
            end
        end else begin
            exp_req.delete();   // flush kills the memory side as well
            pend_resp.delete();
            exp_cdb.delete();
            prev_stall = 1'b0;
        end
        r = $random(seed); // drawn at the edge before any stimulus draw
        #1;
        mem_req_ready_i  = !hold_req && r[0];
        cdb_ready_i      = !cdb_hold && r[1];
        mem_resp_valid_i = pend_resp.size() != 0; // held until taken
        mem_resp_i       = (pend_resp.size() != 0) ? pend_resp[0] : '0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d mismatches, %0d other failures", err_cnt, fail_cnt + 1);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        lsu_uop_t   u0;
        lsu_uop_t   u1;
        lsu_req_t   e0;
        lsu_req_t   e1;
        logic [1:0] v;
        word_t      rb;
        word_t      rs;
        seed             = 32'hab7f_2111;
        arst_n_i         = 1'b0;
        flush_i          = 1'b0;
        disp_valid_i     = 2'b00;
        disp_uop_i       = '0;
        cdb_snoop_i      = '0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_i       = '0;
        cdb_ready_i      = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        check("disp ready after reset", disp_ready_o, 1'b1);
        check("resp ready after reset", mem_resp_ready_o, 1'b1);
        check("req valid after reset", mem_req_valid_o, 1'b0);
        check("cdb valid after reset", cdb_o.valid, 1'b0);

        // ready ops in slot patterns 01, 10 and 11
        repeat (20) begin
            rand_op(u0, e0);
            rand_op(u1, e1);
            v = 2'(($unsigned($random(seed)) % 3) + 1);
            dispatch(v, u0, u1, e0, e1, '0);
        end
        drain();

        // store waiting on both operands with a ready op behind it
        rand_op(u0, e0);
        rand_op(u1, e1);
        rb             = $random(seed);
        rs             = $random(seed);
        u0.op          = MEM_STORE;
        u0.base.rdy    = 1'b0;
        u0.base.tag    = 5'd21;
        u0.sdata.rdy   = 1'b0;
        u0.sdata.tag   = 5'd22;
        e0             = ref_req(u0, rb, rs);
        u0.base.data   = 32'h0bad_0bad; // stale data that the snoop must replace
        u0.sdata.data  = 32'h0bad_0bad;
        dispatch(2'b11, u0, u1, e0, e1, '0);
        repeat (10) @(posedge clk);
        #1;
        check("ops held behind waiting head", exp_req.size(), 2);
        check("no request while head waits", mem_req_valid_o, 1'b0);
        snoop_bus(5'd21, rb);
        snoop_bus(5'd22, rs);
        drain();

        // snoop in the dispatch cycle with both slots on one tag
        rand_op(u0, e0);
        rand_op(u1, e1);
        rb          = $random(seed);
        u0.base.rdy = 1'b0;
        u0.base.tag = 5'd23;
        u1.base.rdy = 1'b0;
        u1.base.tag = 5'd23;
        e0          = ref_req(u0, rb, u0.sdata.data);
        e1          = ref_req(u1, rb, u1.sdata.data);
        dispatch(2'b11, u0, u1, e0, e1, {1'b1, 5'd23, rb});
        drain();

        // request stall fills the queue
        set_holds(1'b1, 1'b0);
        repeat (12) begin
            if (disp_ready_o) begin
                rand_op(u0, e0);
                rand_op(u1, e1);
                dispatch(2'b11, u0, u1, e0, e1, '0);
            end else begin
                @(posedge clk);
                #1;
            end
        end
        check("disp ready with queue full", disp_ready_o, 1'b0);
        check("request pending under stall", mem_req_valid_o, 1'b1);
        set_holds(1'b0, 1'b0);
        drain();

        // commit bus stall fills the response FIFO
        set_holds(1'b0, 1'b1);
        repeat (3) begin
            rand_op(u0, e0);
            rand_op(u1, e1);
            dispatch(2'b11, u0, u1, e0, e1, '0);
        end
        for (int i = 0; i < 200 && mem_resp_ready_o; i++) begin
            @(posedge clk);
            #1;
        end
        check("resp ready with FIFO full", mem_resp_ready_o, 1'b0);
        check("responses buffered", exp_cdb.size(), LSU_RESP_DEPTH);
        set_holds(1'b0, 1'b0);
        drain();

        // flush with responses buffered and ops queued
        set_holds(1'b0, 1'b1);
        rand_op(u0, e0);
        rand_op(u1, e1);
        dispatch(2'b11, u0, u1, e0, e1, '0);
        dispatch(2'b01, u1, u0, e1, e0, '0);
        while (exp_cdb.size() < 3) begin
            @(posedge clk);
            #1;
        end
        set_holds(1'b1, 1'b1);
        repeat (2) begin
            rand_op(u0, e0);
            rand_op(u1, e1);
            dispatch(2'b11, u0, u1, e0, e1, '0);
        end
        repeat (3) @(posedge clk);
        #1;
        flush_i = 1'b1;
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        check("disp ready after flush", disp_ready_o, 1'b1);
        check("req valid after flush", mem_req_valid_o, 1'b0);
        check("cdb valid after flush", cdb_o.valid, 1'b0);
        set_holds(1'b0, 1'b0);
        repeat (20) @(posedge clk);
        #1;
        repeat (2) begin
            rand_op(u0, e0);
            rand_op(u1, e1);
            dispatch(2'b11, u0, u1, e0, e1, '0);
        end
        drain();

        if (exp_req.size() != 0 || exp_cdb.size() != 0 || pend_resp.size() != 0) begin
            fail_cnt++;
            $display("expected requests or responses left over at end of run");
        end
        $display("errors: %0d mismatches, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
